// ==== common/rxPkg.sv ====
// Receiver shared types
// Sample, index, product and decision widths plus the equalizer scaling

package rxPkg;

	// ======================================================================
	// Sample path widths
	// ======================================================================

	// One I or Q component
	typedef logic signed [15:0] sampleT;

	// Sum of two sample products, one bit of headroom
	typedef logic signed [32:0] prodT;

	// Subcarrier position inside a body, up to 256 subcarriers
	typedef logic [7:0] subcarIdxT;

	// QPSK decision, bit 0 from real, bit 1 from imaginary
	typedef logic [1:0] infoBitsT;

	// ======================================================================
	// Constants and state encodings
	// ======================================================================

	// Estimate is 1.14, shift returns product to sample scale
	localparam int EqShift = 14;

	// Guard removal phases
	typedef enum logic {
		sPrefix,
		sBody
	} gapStateT;

endpackage

// ==== common/sampleIf.sv ====
`timescale 1ns/1ps
// Body sample stream between receiver blocks
// One complex sample per beat with its subcarrier index

interface sampleIf
	import rxPkg::*;
();

	// Beat qualifier
	logic      valid;
	// Sample payload
	sampleT    re;
	sampleT    im;
	// Position inside the body
	subcarIdxT idx;
	// Final subcarrier of the body
	logic      last;

	// Producer side
	modport source (output valid, re, im, idx, last);

	// Consumer side
	modport sink (input valid, re, im, idx, last);

endinterface

// ==== guardRemoval/guardRemoval.sv ====
`timescale 1ns/1ps
// Guard interval removal
// Drops the cyclic prefix, indexes body samples, steers pilot or data bodies

module guardRemoval
	import rxPkg::*;
#(
	parameter int NumSubcar = 16,
	parameter int PrefixLen = 4
) (
	input  logic   clk,
	input  logic   arstN,
	input  logic   inValid,
	output logic   inReady,
	input  sampleT inRe,
	input  sampleT inIm,
	input  logic   inFirst,
	input  logic   inPilot,
	input  logic   eqReady,
	sampleIf.source pilotBus,
	sampleIf.source dataBus
);

	// Terminal counts
	localparam subcarIdxT LastPrefix = subcarIdxT'(PrefixLen - 1);
	localparam subcarIdxT LastSubcar = subcarIdxT'(NumSubcar - 1);

	gapStateT  state;
	subcarIdxT cnt;
	// Symbol type, captured on its first sample
	logic      pilotQ;

	logic      accept;
	logic      restart;
	logic      bodyValid;
	subcarIdxT prefIdx;

	// ======================================================================
	// Handshake and steering
	// ======================================================================

	// Prefix and pilot samples are always taken, data waits on the equalizer
	assign inReady = (state == sPrefix) || pilotQ || eqReady;
	assign accept  = inValid && inReady;

	// First sample always counts as prefix sample zero
	assign restart = inValid && inFirst;
	assign prefIdx = restart ? '0 : cnt;

	// Body beat, never a restart
	assign bodyValid = inValid && !inFirst && (state == sBody);

	// Pilot bodies
	assign pilotBus.valid = bodyValid && pilotQ;
	assign pilotBus.re    = inRe;
	assign pilotBus.im    = inIm;
	assign pilotBus.idx   = cnt;
	assign pilotBus.last  = (cnt == LastSubcar);

	// Data bodies
	assign dataBus.valid = bodyValid && !pilotQ;
	assign dataBus.re    = inRe;
	assign dataBus.im    = inIm;
	assign dataBus.idx   = cnt;
	assign dataBus.last  = (cnt == LastSubcar);

	// ======================================================================
	// Prefix / body counter
	// ======================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state  <= sPrefix;
			cnt    <= '0;
			pilotQ <= 1'b0;
		end else if (accept) begin
			if (restart || state == sPrefix) begin
				if (restart) begin
					pilotQ <= inPilot;
				end
				// Prefix sample discarded, move on after the last one
				if (prefIdx == LastPrefix) begin
					state <= sBody;
					cnt   <= '0;
				end else begin
					state <= sPrefix;
					cnt   <= prefIdx + 1'b1;
				end
			end else begin
				// Body sample forwarded on one of the buses
				if (cnt == LastSubcar) begin
					state <= sPrefix;
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== channelEst/channelEst.sv ====
`timescale 1ns/1ps
// Channel estimate store
// Keeps the latest pilot body per subcarrier, pilot assumed sent as +1

module channelEst
	import rxPkg::*;
#(
	parameter int NumSubcar = 16
) (
	input  logic      clk,
	input  logic      arstN,
	sampleIf.sink     pilotBus,
	input  subcarIdxT rdIdx,
	output sampleT    hRe,
	output sampleT    hIm
);

	// Address width for the table
	localparam int AddrW = (NumSubcar > 1) ? $clog2(NumSubcar) : 1;

	// One complex entry per subcarrier
	sampleT memRe [NumSubcar];
	sampleT memIm [NumSubcar];

	logic [AddrW-1:0] wrAddr;
	logic [AddrW-1:0] rdAddr;

	assign wrAddr = pilotBus.idx[AddrW-1:0];
	assign rdAddr = rdIdx[AddrW-1:0];

	// ======================================================================
	// Pilot capture
	// ======================================================================

	// Newest pilot overwrites, readable next cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumSubcar; i++) begin
				memRe[i] <= '0;
				memIm[i] <= '0;
			end
		end else if (pilotBus.valid) begin
			// Received value equals the channel for a +1 pilot
			memRe[wrAddr] <= pilotBus.re;
			memIm[wrAddr] <= pilotBus.im;
		end
	end

	// ======================================================================
	// Read port
	// ======================================================================

	// Asynchronous lookup for the equalizer
	assign hRe = memRe[rdAddr];
	assign hIm = memIm[rdAddr];

endmodule

// ==== equalizer/equalizer.sv ====
`timescale 1ns/1ps
// Conjugate equalizer with QPSK slicer
// Two stage pipeline, y times conj(h), scaled back to sample width

module equalizer
	import rxPkg::*;
#(
	parameter int NumSubcar = 16
) (
	input  logic      clk,
	input  logic      arstN,
	sampleIf.sink     dataBus,
	output logic      eqReady,

	// Estimate lookup
	output subcarIdxT hIdx,
	input  sampleT    hRe,
	input  sampleT    hIm,

	// Result stream
	output logic      outValid,
	input  logic      outReady,
	output sampleT    outRe,
	output sampleT    outIm,
	output infoBitsT  outBits,
	output logic      outLast
);

	// Stage one
	logic   s1Valid;
	logic   s1Last;
	sampleT s1YRe;
	sampleT s1YIm;
	sampleT s1HRe;
	sampleT s1HIm;

	// Stage two arithmetic
	logic   advance;
	prodT   sumRe;
	prodT   sumIm;
	sampleT eqRe;
	sampleT eqIm;

	// ======================================================================
	// Flow control and lookup
	// ======================================================================

	// Whole pipe moves together, output slot free or being drained
	assign advance = outReady || !outValid;
	assign eqReady = advance;

	// Keep the table read inside the body range
	assign hIdx = (dataBus.idx < subcarIdxT'(NumSubcar)) ? dataBus.idx : '0;

	// ======================================================================
	// Conjugate multiply
	// ======================================================================

	// (yRe + j yIm) * (hRe - j hIm)
	assign sumRe = prodT'(s1HRe) * prodT'(s1YRe) + prodT'(s1HIm) * prodT'(s1YIm);
	assign sumIm = prodT'(s1HRe) * prodT'(s1YIm) - prodT'(s1HIm) * prodT'(s1YRe);

	// Back to 1.14 sample scale, low 16 bits kept
	assign eqRe = sampleT'(sumRe >>> EqShift);
	assign eqIm = sampleT'(sumIm >>> EqShift);

	// ======================================================================
	// Pipeline registers
	// ======================================================================

	// Valid flags
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			s1Valid  <= 1'b0;
			outValid <= 1'b0;
		end else if (advance) begin
			s1Valid  <= dataBus.valid;
			outValid <= s1Valid;
		end
	end

	// Payload, held under back-pressure
	always_ff @(posedge clk) begin
		if (advance) begin
			// Sample with its estimate
			s1YRe  <= dataBus.re;
			s1YIm  <= dataBus.im;
			s1HRe  <= hRe;
			s1HIm  <= hIm;
			s1Last <= dataBus.last;

			// Equalized symbol and hard decision
			outRe   <= eqRe;
			outIm   <= eqIm;
			outBits <= {eqIm[15], eqRe[15]};  // negative component gives a one
			outLast <= s1Last;
		end
	end

endmodule

// ==== src/ofdmReceiver.sv ====
`timescale 1ns/1ps
// OFDM receiver back end
// Prefix removal, pilot based channel estimate, conjugate equalizer, QPSK slicer

module ofdmReceiver
	import rxPkg::*;
#(
	parameter int NumSubcar = 16,
	parameter int PrefixLen = 4
) (
	input  logic     clk,
	input  logic     arstN,

	// Time domain sample input
	input  logic     inValid,
	output logic     inReady,
	input  sampleT   inRe,
	input  sampleT   inIm,
	input  logic     inFirst,
	input  logic     inPilot,

	// Equalized symbols and decisions
	output logic     outValid,
	input  logic     outReady,
	output sampleT   outRe,
	output sampleT   outIm,
	output infoBitsT outBits,
	output logic     outLast
);

	// ======================================================================
	// Internal buses
	// ======================================================================

	// Pilot bodies toward the estimator, always accepted
	sampleIf pilotBus ();
	// Data bodies toward the equalizer
	sampleIf dataBus ();

	// Data path back-pressure
	logic      eqReady;

	// Estimate lookup
	subcarIdxT rdIdx;
	sampleT    hRe;
	sampleT    hIm;

	// ======================================================================
	// Blocks
	// ======================================================================

	guardRemoval #(
		.NumSubcar (NumSubcar),
		.PrefixLen (PrefixLen)
	) guardRemovalInst (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inRe     (inRe),
		.inIm     (inIm),
		.inFirst  (inFirst),
		.inPilot  (inPilot),
		.eqReady  (eqReady),
		.pilotBus (pilotBus),
		.dataBus  (dataBus)
	);

	channelEst #(
		.NumSubcar (NumSubcar)
	) channelEstInst (
		.clk      (clk),
		.arstN    (arstN),
		.pilotBus (pilotBus),
		.rdIdx    (rdIdx),
		.hRe      (hRe),
		.hIm      (hIm)
	);

	equalizer #(
		.NumSubcar (NumSubcar)
	) equalizerInst (
		.clk      (clk),
		.arstN    (arstN),
		.dataBus  (dataBus),
		.eqReady  (eqReady),
		.hIdx     (rdIdx),
		.hRe      (hRe),
		.hIm      (hIm),
		.outValid (outValid),
		.outReady (outReady),
		.outRe    (outRe),
		.outIm    (outIm),
		.outBits  (outBits),
		.outLast  (outLast)
	);

endmodule

// ==== verification/tbModel.svh ====
// Reference model for the equalized receiver output
// y times conj(h) at 1.14 scale, then QPSK sign decisions
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Real part, hRe*yRe + hIm*yIm scaled down
function automatic sampleT eqRealPart(input sampleT yRe, input sampleT yIm,
		input sampleT hRe, input sampleT hIm);
	longint acc;
	acc = longint'(hRe) * longint'(yRe) + longint'(hIm) * longint'(yIm);
	acc = acc >>> EqShift;
	return sampleT'(acc);
endfunction

// Imaginary part, hRe*yIm - hIm*yRe scaled down
function automatic sampleT eqImagPart(input sampleT yRe, input sampleT yIm,
		input sampleT hRe, input sampleT hIm);
	longint acc;
	acc = longint'(hRe) * longint'(yIm) - longint'(hIm) * longint'(yRe);
	acc = acc >>> EqShift;
	return sampleT'(acc);
endfunction

// Hard decision, a negative component gives a one
function automatic infoBitsT qpskBits(input sampleT re, input sampleT im);
	return {im < 0, re < 0};
endfunction

`endif

// ==== verification/tbOfdmReceiver.sv ====
`timescale 1ns/1ps
// Testbench for the OFDM receiver back end
// Sends pilot and data symbols and scoreboards the equalized stream

module tbOfdmReceiver;
	import rxPkg::*;

	localparam int NumSubcar = 16;
	localparam int PrefixLen = 4;
	localparam int SymLen = NumSubcar + PrefixLen;
	// About 20 symbols with stalls stretching each up to seven times
	localparam int TimeoutCycles = 20 * SymLen * 7 + 200;

	typedef struct packed {
		logic     last;
		infoBitsT bits;
		sampleT   im;
		sampleT   re;
	} beatT;

	logic     clk = 1'b0;
	logic     arstN;
	logic     inValid;
	logic     inReady;
	sampleT   inRe;
	sampleT   inIm;
	logic     inFirst;
	logic     inPilot;
	logic     outValid;
	logic     outReady = 1'b1;
	sampleT   outRe;
	sampleT   outIm;
	infoBitsT outBits;
	logic     outLast;

	int       seed = 32'hb2b;
	// Estimate copy and expected beats
	sampleT   estRe [NumSubcar] = '{default: '0};
	sampleT   estIm [NumSubcar] = '{default: '0};
	beatT     expQ [$];
	logic     readyPat [256];
	logic [7:0] phase = '0;
	logic     randomReady = 1'b0;
	// Output held off completely
	logic     holdOut = 1'b0;
	logic     dataBody = 1'b0;
	int       cycles = 0;
	int       errCnt = 0;
	int       stimErrs = 0;
	int       errMark = 0;
	int       outCount = 0;
	int       lastCount = 0;
	int       snapOut = 0;
	int       snapLast = 0;
	int       testsRun = 0;
	int       testsFailed = 0;

	`include "tbModel.svh"

	ofdmReceiver #(.NumSubcar(NumSubcar), .PrefixLen(PrefixLen)) i_dut (.*);

	always #5 clk = ~clk;

	// Output back-pressure driven on the falling edge
	always @(negedge clk) begin
		if (holdOut)
			outReady = 1'b0;
		else
			outReady = randomReady ? readyPat[phase] : 1'b1;
		phase = phase + 1'b1;
	end

	// ======================================================================
	// Checks
	// ======================================================================

	quietInReset: assert property (@(posedge clk) !arstN |-> !outValid)
		else begin
			$display("outValid was high during reset");
			errCnt++;
		end

	// Input stalls are only allowed inside data bodies
	stallOnlyInData: assert property (@(posedge clk) disable iff (!arstN) !inReady |-> dataBody)
		else begin
			$display("inReady dropped outside a data body");
			errCnt++;
		end

	always @(posedge clk) begin : scoreboard
		beatT head;
		if (arstN && outValid && outReady) begin
			outCount++;
			if (outLast)
				lastCount++;
			expectedBeat: assert (expQ.size() != 0) else begin
				$display("output beat %0d arrived with nothing expected", outCount);
				errCnt++;
			end
			if (expQ.size() != 0) begin
				head = expQ.pop_front();
				reOk: assert (outRe == head.re) else begin
					$display("[FAIL] outRe got %h expected %h", outRe, head.re);
					errCnt++;
				end
				imOk: assert (outIm == head.im) else begin
					$display("[FAIL] outIm got %h expected %h", outIm, head.im);
					errCnt++;
				end
				bitsOk: assert (outBits == head.bits) else begin
					$display("[FAIL] outBits got %h expected %h", outBits, head.bits);
					errCnt++;
				end
				lastOk: assert (outLast == head.last) else begin
					$display("[FAIL] outLast got %h expected %h", outLast, head.last);
					errCnt++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	// One prefix plus body with expected beats queued on acceptance
	task automatic sendSymbol(input logic isPilot);
		sampleT re;
		sampleT im;
		beatT   exp;
		int     sc;
		for (int k = 0; k < SymLen; k++) begin
			sc = k - PrefixLen;
			if (k < PrefixLen) begin
				// Marker values for the prefix
				re = sampleT'(16'h7f00 + k);
				im = sampleT'(16'h8100 + k);
			end else if (isPilot) begin
				re = sampleT'($random(seed) % 16384);
				im = sampleT'($random(seed) % 16384);
			end else begin
				re = sampleT'($random(seed));
				im = sampleT'($random(seed));
			end
			@(negedge clk);
			inValid = 1'b1;
			inRe = re;
			inIm = im;
			inFirst = (k == 0);
			inPilot = isPilot;
			dataBody = !isPilot && (k >= PrefixLen);
			@(posedge clk);
			while (!inReady)
				@(posedge clk);
			if (k >= PrefixLen && isPilot) begin
				estRe[sc] = re;
				estIm[sc] = im;
			end else if (k >= PrefixLen) begin
				exp.re = eqRealPart(re, im, estRe[sc], estIm[sc]);
				exp.im = eqImagPart(re, im, estRe[sc], estIm[sc]);
				exp.bits = qpskBits(exp.re, exp.im);
				exp.last = (k == SymLen - 1);
				expQ.push_back(exp);
			end
		end
		@(negedge clk);
		inValid = 1'b0;
		inFirst = 1'b0;
		dataBody = 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (6) @(posedge clk);
	endtask

	task automatic checkCounts(input int nOut, input int nLast);
		countOk: assert (outCount - snapOut == nOut && lastCount - snapLast == nLast) else begin
			$display("[FAIL] outValid beats got %h expected %h, outLast beats got %h expected %h",
				outCount - snapOut, nOut, lastCount - snapLast, nLast);
			stimErrs++;
		end
		snapOut = outCount;
		snapLast = lastCount;
	endtask

	task automatic closeTest(input string name);
		int errs;
		errs = errCnt + stimErrs - errMark;
		testsRun++;
		if (errs != 0)
			testsFailed++;
		$display("test %0d %s: %0d errors", testsRun, name, errs);
		errMark = errCnt + stimErrs;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		arstN = 1'b0;
		inValid = 1'b0;
		inRe = '0;
		inIm = '0;
		inFirst = 1'b0;
		inPilot = 1'b0;
		for (int i = 0; i < 256; i++)
			readyPat[i] = 1'($random(seed));
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		// Zero estimate gives zero outputs
		idleLow: assert (!outValid) else begin
			$display("outValid high after reset before any input");
			stimErrs++;
		end
		sendSymbol(1'b0);
		drain();
		checkCounts(NumSubcar, 1);
		closeTest("data before pilot");

		// Pilot stays silent and data shows only its body
		sendSymbol(1'b1);
		repeat (10) @(posedge clk);
		checkCounts(0, 0);
		sendSymbol(1'b0);
		drain();
		checkCounts(NumSubcar, 1);
		closeTest("prefix removal");

		repeat (2) sendSymbol(1'b0);
		drain();
		checkCounts(2 * NumSubcar, 2);
		closeTest("equalized data");

		sendSymbol(1'b1);
		repeat (2) sendSymbol(1'b0);
		drain();
		checkCounts(2 * NumSubcar, 2);
		closeTest("estimate update");

		randomReady = 1'b1;
		sendSymbol(1'b1);
		repeat (6) sendSymbol(1'b0);
		drain();
		randomReady = 1'b0;
		checkCounts(6 * NumSubcar, 6);
		// Pilot body arrives while the output stage is stuck
		sendSymbol(1'b0);
		@(posedge clk);
		holdOut = 1'b1;
		sendSymbol(1'b1);
		@(posedge clk);
		holdOut = 1'b0;
		drain();
		checkCounts(NumSubcar, 1);
		closeTest("output back-pressure");

		$display("tests run %0d, tests failed %0d, errors %0d",
			testsRun, testsFailed, errCnt + stimErrs);
		if (testsFailed == 0 && errCnt + stimErrs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+verification
common/rxPkg.sv
common/sampleIf.sv
guardRemoval/guardRemoval.sv
channelEst/channelEst.sv
equalizer/equalizer.sv
src/ofdmReceiver.sv
verification/tbOfdmReceiver.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the OFDM receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module tbOfdmReceiver --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
